// File: include/atop_cfg.svh
/*
 * Widths and limits of the atomic resolver.
 * The data width must equal the 32-bit RISC-V word.
 */
`ifndef ATOP_CFG_SVH
`define ATOP_CFG_SVH

// Byte address width on both ports
`define ATOP_ADDR_W 32

// Bus data width, equal to the RISC-V word
`define ATOP_DATA_W 32

`define ATOP_ID_W 4

// Plain accesses in flight, also the depth of the response metadata FIFO
`define ATOP_MAX_OUTSTANDING 2

`endif

// File: hdl/atop_pkg.sv
/*
 * Types shared by the atomic resolver.
 * Opcodes follow the RISC-V AMO funct5 encoding with bit 5 set.
 */
`include "atop_cfg.svh"

package atop_pkg;

  typedef logic [`ATOP_ADDR_W-1:0]   addr_t;
  typedef logic [`ATOP_DATA_W-1:0]   data_t;
  typedef logic [`ATOP_DATA_W/8-1:0] be_t;
  typedef logic [`ATOP_ID_W-1:0]     id_t;

  // Atomic opcode as carried on the bus
  typedef enum logic [5:0] {
    ATOP_NONE = 6'h00,
    ATOP_ADD  = 6'h20,
    ATOP_SWAP = 6'h21,
    ATOP_LR   = 6'h22,
    ATOP_SC   = 6'h23,
    ATOP_XOR  = 6'h24,
    ATOP_OR   = 6'h28,
    ATOP_AND  = 6'h2C,
    ATOP_MIN  = 6'h30,
    ATOP_MAX  = 6'h34,
    ATOP_MINU = 6'h38,
    ATOP_MAXU = 6'h3C
  } atop_e;

  typedef enum logic [1:0] {KIND_PLAIN, KIND_LR, KIND_SC, KIND_AMO} atop_kind_e;

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT_READ, ST_WRITE_BACK, ST_WAIT_WB_RSP} amo_state_e;

endpackage

// File: hdl/atop_req_if.sv
/*
 * Accepted request as seen by the reservation and response blocks.
 * sc_ok is combinational and only meaningful while accept is high.
 */
`timescale 1ns/1ns
`include "atop_cfg.svh"

interface atop_req_if;

  logic                 accept;
  atop_pkg::atop_kind_e kind;
  atop_pkg::addr_t      addr;
  logic                 we;
  atop_pkg::id_t        aid;
  logic                 sc_ok;

  modport ctrl (output accept, kind, addr, we, aid, input sc_ok);

  modport lrsc (input accept, kind, addr, we, aid, output sc_ok);

  modport rsp (input accept, kind, aid, sc_ok);

endinterface

// File: hdl/atop_amo_ctrl.sv
/*
 * Request side of the atomic resolver. An AMO is granted only with nothing
 * outstanding and blocks further grants until its write-back has completed.
 * The write-back always enables all byte lanes.
 */
`timescale 1ns/1ns
`include "atop_cfg.svh"

module atop_amo_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              sbr_req_i,
  output logic              sbr_gnt_o,
  input  atop_pkg::addr_t   sbr_addr_i,
  input  logic              sbr_we_i,
  input  atop_pkg::be_t     sbr_be_i,
  input  atop_pkg::data_t   sbr_wdata_i,
  input  atop_pkg::id_t     sbr_aid_i,
  input  atop_pkg::atop_e   sbr_atop_i,
  output logic              mgr_req_o,
  input  logic              mgr_gnt_i,
  output atop_pkg::addr_t   mgr_addr_o,
  output logic              mgr_we_o,
  output atop_pkg::be_t     mgr_be_o,
  output atop_pkg::data_t   mgr_wdata_o,
  input  logic              mgr_rvalid_i,
  output atop_pkg::atop_e   amo_op_o,
  output atop_pkg::data_t   amo_operand_o,
  output logic              amo_capture_o,
  input  atop_pkg::data_t   amo_result_i,
  output logic              rsp_hide_o,
  atop_req_if.ctrl          req_if
);

  localparam int CNT_W = $clog2(`ATOP_MAX_OUTSTANDING + 1);

  atop_pkg::amo_state_e state_q, state_d;
  atop_pkg::atop_kind_e kind;
  logic [CNT_W-1:0]     outstanding_q;
  logic                 can_issue;
  logic                 take;
  logic                 give;
  atop_pkg::addr_t      addr_q;
  atop_pkg::data_t      operand_q;
  atop_pkg::atop_e      op_q;

  // Everything with bit 5 set that is not LR or SC is an AMO
  always_comb begin
    case (sbr_atop_i)
      atop_pkg::ATOP_LR: kind = atop_pkg::KIND_LR;
      atop_pkg::ATOP_SC: kind = atop_pkg::KIND_SC;
      default:           kind = sbr_atop_i[5] ? atop_pkg::KIND_AMO : atop_pkg::KIND_PLAIN;
    endcase
  end

  // An AMO needs an empty pipeline so its read response is the next one back
  assign can_issue = (state_q == atop_pkg::ST_IDLE) &&
                     ((kind == atop_pkg::KIND_AMO) ? (outstanding_q == '0) :
                                                     (outstanding_q < `ATOP_MAX_OUTSTANDING));

  assign sbr_gnt_o = sbr_req_i & can_issue & mgr_gnt_i;

  // --------------------
  // Manager request mux
  // --------------------
  always_comb begin
    mgr_req_o   = sbr_req_i & can_issue;
    mgr_addr_o  = sbr_addr_i;
    mgr_be_o    = sbr_be_i;
    mgr_wdata_o = sbr_wdata_i;
    case (kind)
      atop_pkg::KIND_SC:  mgr_we_o = req_if.sc_ok;
      atop_pkg::KIND_LR,
      atop_pkg::KIND_AMO: mgr_we_o = 1'b0;
      default:            mgr_we_o = sbr_we_i;
    endcase
    if (state_q == atop_pkg::ST_WRITE_BACK) begin
      mgr_req_o   = 1'b1;
      mgr_addr_o  = addr_q;
      mgr_be_o    = '1;
      mgr_wdata_o = amo_result_i;
      mgr_we_o    = 1'b1;
    end
  end

  assign take = mgr_req_o & mgr_gnt_i;
  assign give = mgr_rvalid_i;

  assign req_if.accept = sbr_gnt_o;
  assign req_if.kind   = kind;
  assign req_if.addr   = sbr_addr_i;
  assign req_if.we     = sbr_we_i;
  assign req_if.aid    = sbr_aid_i;

  // --------------------
  // AMO state machine
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      atop_pkg::ST_IDLE:
        if (req_if.accept && kind == atop_pkg::KIND_AMO) state_d = atop_pkg::ST_WAIT_READ;
      atop_pkg::ST_WAIT_READ:
        if (mgr_rvalid_i) state_d = atop_pkg::ST_WRITE_BACK;
      atop_pkg::ST_WRITE_BACK:
        if (mgr_gnt_i) state_d = atop_pkg::ST_WAIT_WB_RSP;
      default:
        if (mgr_rvalid_i) state_d = atop_pkg::ST_IDLE;
    endcase
  end

  assign amo_capture_o = (state_q == atop_pkg::ST_WAIT_READ) && mgr_rvalid_i;
  assign rsp_hide_o    = (state_q == atop_pkg::ST_WAIT_WB_RSP);
  assign amo_op_o      = op_q;
  assign amo_operand_o = operand_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= atop_pkg::ST_IDLE;
      outstanding_q <= '0;
    end else begin
      state_q <= state_d;
      if (take && !give) begin
        outstanding_q <= outstanding_q + 1'b1;
      end else if (give && !take) begin
        outstanding_q <= outstanding_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_if.accept && kind == atop_pkg::KIND_AMO) begin
      addr_q    <= sbr_addr_i;
      operand_q <= sbr_wdata_i;
      op_q      <= sbr_atop_i;
    end
  end

endmodule

// File: hdl/atop_amo_alu.sv
/*
 * AMO arithmetic on one 32-bit word. The old memory value is captured
 * on the read response and the result is valid from the next cycle on.
 */
`timescale 1ns/1ns
`include "atop_cfg.svh"

module atop_amo_alu (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            capture_i,
  input  atop_pkg::data_t mem_rdata_i,
  input  atop_pkg::atop_e op_i,
  input  atop_pkg::data_t operand_i,
  output atop_pkg::data_t result_o
);

  localparam int W = `ATOP_DATA_W;

  atop_pkg::data_t old_q;
  logic            is_signed;
  logic [W:0]      diff;
  logic            less;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      old_q <= '0;
    end else if (capture_i) begin
      old_q <= mem_rdata_i;
    end
  end

  // One subtractor serves all four compares, sign or zero extension picks the flavour
  assign is_signed = (op_i == atop_pkg::ATOP_MIN) || (op_i == atop_pkg::ATOP_MAX);
  assign diff      = {is_signed & old_q[W-1], old_q} - {is_signed & operand_i[W-1], operand_i};
  // The extra top bit is set when the old value is the smaller one
  assign less      = diff[W];

  always_comb begin
    case (op_i)
      atop_pkg::ATOP_ADD:  result_o = old_q + operand_i;
      atop_pkg::ATOP_XOR:  result_o = old_q ^ operand_i;
      atop_pkg::ATOP_AND:  result_o = old_q & operand_i;
      atop_pkg::ATOP_OR:   result_o = old_q | operand_i;
      atop_pkg::ATOP_MIN,
      atop_pkg::ATOP_MINU: result_o = less ? old_q : operand_i;
      atop_pkg::ATOP_MAX,
      atop_pkg::ATOP_MAXU: result_o = less ? operand_i : old_q;
      // SWAP writes the operand unchanged
      default:             result_o = operand_i;
    endcase
  end

endmodule

// File: hdl/atop_lrsc_monitor.sv
/*
 * Single LR/SC reservation on an exact word address.
 * Another ID cannot take over a held reservation with its own LR,
 * so the first requester keeps it until its SC or a conflicting store.
 */
`timescale 1ns/1ns
`include "atop_cfg.svh"

module atop_lrsc_monitor (
  input logic      clk_i,
  input logic      rst_ni,
  atop_req_if.lrsc req_if
);

  logic            res_valid_q;
  atop_pkg::addr_t res_addr_q;
  atop_pkg::id_t   res_id_q;
  logic            owner;
  logic            hit;
  logic            store;

  assign owner = (res_id_q == req_if.aid);
  assign hit   = (res_addr_q == req_if.addr);
  assign store = (req_if.kind == atop_pkg::KIND_AMO) ||
                 (req_if.kind == atop_pkg::KIND_PLAIN && req_if.we);

  // Success of the request on the bus, looked at by the controller before the grant
  always_comb begin
    case (req_if.kind)
      atop_pkg::KIND_LR: req_if.sc_ok = !res_valid_q || owner;
      atop_pkg::KIND_SC: req_if.sc_ok = res_valid_q && owner && hit;
      default:           req_if.sc_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (req_if.accept) begin
      if (req_if.kind == atop_pkg::KIND_LR && req_if.sc_ok) begin
        res_valid_q <= 1'b1;
      end else if (req_if.kind == atop_pkg::KIND_SC && res_valid_q && owner) begin
        // Any SC of the owner ends the reservation, matching or not
        res_valid_q <= 1'b0;
      end else if (res_valid_q && !owner && hit && store) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_if.accept && req_if.kind == atop_pkg::KIND_LR && req_if.sc_ok) begin
      res_addr_q <= req_if.addr;
      res_id_q   <= req_if.aid;
    end
  end

endmodule

// File: hdl/atop_rsp_path.sv
/*
 * Response side of the atomic resolver. Metadata of each accepted request
 * waits in a small FIFO until its response, which cannot be stalled.
 * The controller keeps the FIFO from overflowing.
 */
`timescale 1ns/1ns
`include "atop_cfg.svh"

module atop_rsp_path (
  input  logic            clk_i,
  input  logic            rst_ni,
  atop_req_if.rsp         req_if,
  input  logic            rsp_hide_i,
  input  logic            mgr_rvalid_i,
  input  atop_pkg::data_t mgr_rdata_i,
  input  logic            mgr_err_i,
  output logic            sbr_rvalid_o,
  output atop_pkg::data_t sbr_rdata_o,
  output atop_pkg::id_t   sbr_rid_o,
  output logic            sbr_err_o,
  output logic            sbr_exokay_o
);

  localparam int DEPTH = `ATOP_MAX_OUTSTANDING;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  atop_pkg::id_t    aid_mem [DEPTH];
  logic             sc_mem  [DEPTH];
  logic             ok_mem  [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic             push;
  logic             pop;
  logic             head_sc;

  assign push = req_if.accept;
  assign pop  = sbr_rvalid_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      aid_mem[wr_ptr_q] <= req_if.aid;
      sc_mem[wr_ptr_q]  <= (req_if.kind == atop_pkg::KIND_SC);
      ok_mem[wr_ptr_q]  <= req_if.sc_ok;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  // --------------------
  // Requester response
  // --------------------
  assign head_sc      = sc_mem[rd_ptr_q];
  assign sbr_rvalid_o = mgr_rvalid_i & ~rsp_hide_i;
  assign sbr_rid_o    = aid_mem[rd_ptr_q];
  assign sbr_err_o    = mgr_err_i;
  assign sbr_exokay_o = ok_mem[rd_ptr_q];

  // SC answers 0 on success and 1 on failure instead of memory data
  assign sbr_rdata_o = head_sc ? {{(`ATOP_DATA_W - 1){1'b0}}, ~ok_mem[rd_ptr_q]} : mgr_rdata_i;

endmodule

// File: hdl/atop_resolver.sv
/*
 * Atomic-operation resolver in front of a memory with exclusive access.
 * OBI-style req/gnt request phase and rvalid response phase, no rready.
 * Responses return in request order.
 */
`timescale 1ns/1ns
`include "atop_cfg.svh"

module atop_resolver (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            sbr_req_i,
  output logic            sbr_gnt_o,
  input  atop_pkg::addr_t sbr_addr_i,
  input  logic            sbr_we_i,
  input  atop_pkg::be_t   sbr_be_i,
  input  atop_pkg::data_t sbr_wdata_i,
  input  atop_pkg::id_t   sbr_aid_i,
  input  atop_pkg::atop_e sbr_atop_i,
  output logic            sbr_rvalid_o,
  output atop_pkg::data_t sbr_rdata_o,
  output atop_pkg::id_t   sbr_rid_o,
  output logic            sbr_err_o,
  output logic            sbr_exokay_o,
  output logic            mgr_req_o,
  input  logic            mgr_gnt_i,
  output atop_pkg::addr_t mgr_addr_o,
  output logic            mgr_we_o,
  output atop_pkg::be_t   mgr_be_o,
  output atop_pkg::data_t mgr_wdata_o,
  input  logic            mgr_rvalid_i,
  input  atop_pkg::data_t mgr_rdata_i,
  input  logic            mgr_err_i
);

  atop_pkg::atop_e amo_op;
  atop_pkg::data_t amo_operand;
  atop_pkg::data_t amo_result;
  logic            amo_capture;
  logic            rsp_hide;

  atop_req_if u_req_if ();

  atop_amo_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sbr_req_i     (sbr_req_i),
    .sbr_gnt_o     (sbr_gnt_o),
    .sbr_addr_i    (sbr_addr_i),
    .sbr_we_i      (sbr_we_i),
    .sbr_be_i      (sbr_be_i),
    .sbr_wdata_i   (sbr_wdata_i),
    .sbr_aid_i     (sbr_aid_i),
    .sbr_atop_i    (sbr_atop_i),
    .mgr_req_o     (mgr_req_o),
    .mgr_gnt_i     (mgr_gnt_i),
    .mgr_addr_o    (mgr_addr_o),
    .mgr_we_o      (mgr_we_o),
    .mgr_be_o      (mgr_be_o),
    .mgr_wdata_o   (mgr_wdata_o),
    .mgr_rvalid_i  (mgr_rvalid_i),
    .amo_op_o      (amo_op),
    .amo_operand_o (amo_operand),
    .amo_capture_o (amo_capture),
    .amo_result_i  (amo_result),
    .rsp_hide_o    (rsp_hide),
    .req_if        (u_req_if.ctrl)
  );

  atop_amo_alu u_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .capture_i   (amo_capture),
    .mem_rdata_i (mgr_rdata_i),
    .op_i        (amo_op),
    .operand_i   (amo_operand),
    .result_o    (amo_result)
  );

  atop_lrsc_monitor u_lrsc (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_if (u_req_if.lrsc)
  );

  atop_rsp_path u_rsp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_if       (u_req_if.rsp),
    .rsp_hide_i   (rsp_hide),
    .mgr_rvalid_i (mgr_rvalid_i),
    .mgr_rdata_i  (mgr_rdata_i),
    .mgr_err_i    (mgr_err_i),
    .sbr_rvalid_o (sbr_rvalid_o),
    .sbr_rdata_o  (sbr_rdata_o),
    .sbr_rid_o    (sbr_rid_o),
    .sbr_err_o    (sbr_err_o),
    .sbr_exokay_o (sbr_exokay_o)
  );

endmodule

// File: tb/atop_resolver_chk.sv
/*
 * Protocol assertions for the AMO controller, bound into every instance.
 */
`timescale 1ns/1ns
`include "atop_cfg.svh"

module atop_resolver_chk #(
  parameter int CNT_W = $clog2(`ATOP_MAX_OUTSTANDING + 1)
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input atop_pkg::amo_state_e state_i,
  input logic [CNT_W-1:0]     outstanding_i,
  input logic                 sbr_gnt_i,
  input logic                 mgr_req_i,
  input logic                 mgr_gnt_i
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // No new request enters while an AMO is in progress
  a_no_gnt_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i != atop_pkg::ST_IDLE) |-> !sbr_gnt_i)
    else begin
      fail_count++;
      $error("Grant issued while the AMO state machine is busy");
    end

  a_outstanding_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_i <= CNT_W'(`ATOP_MAX_OUTSTANDING))
    else begin
      fail_count++;
      $error("Outstanding count above its limit");
    end

  // The write-back request is held under back-pressure
  a_wb_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == atop_pkg::ST_WRITE_BACK && !mgr_gnt_i) |=>
    (state_i == atop_pkg::ST_WRITE_BACK && mgr_req_i))
    else begin
      fail_count++;
      $error("Write-back request dropped before its grant");
    end

endmodule

bind atop_amo_ctrl atop_resolver_chk u_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .state_i       (state_q),
  .outstanding_i (outstanding_q),
  .sbr_gnt_i     (sbr_gnt_o),
  .mgr_req_i     (mgr_req_o),
  .mgr_gnt_i     (mgr_gnt_i)
);

// File: tb/tb_mem_model.sv
/*
 * Word memory behind the manager port, cleared by reset, 64 words deep.
 * Read data returns one cycle after the grant, writes answer with zero.
 * Grants are withheld on pseudo-random cycles.
 */
`timescale 1ns/1ns
`include "atop_cfg.svh"

module tb_mem_model (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  output logic            gnt_o,
  input  atop_pkg::addr_t addr_i,
  input  logic            we_i,
  input  atop_pkg::be_t   be_i,
  input  atop_pkg::data_t wdata_i,
  output logic            rvalid_o,
  output atop_pkg::data_t rdata_o,
  output logic            err_o
);

  localparam int          WORDS = 64;
  localparam logic [31:0] SEED  = 32'h51bf;

  atop_pkg::data_t mem [WORDS];
  logic [31:0]     lfsr_q;
  logic [31:0]     lfsr_mid;
  logic            stall_q;
  logic [5:0]      idx;

  // Galois form shifting right, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  assign lfsr_mid = lfsr_step(lfsr_q);
  assign idx      = addr_i[7:2];
  assign gnt_o    = req_i & ~stall_q;
  assign err_o    = 1'b0;

  // Two LFSR bits per cycle, a stall when both are set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q   <= SEED;
      stall_q  <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      lfsr_q   <= lfsr_step(lfsr_mid);
      stall_q  <= lfsr_q[0] & lfsr_mid[0];
      rvalid_o <= req_i & gnt_o;
      if (req_i && gnt_o) begin
        rdata_o <= we_i ? '0 : mem[idx];
        for (int b = 0; b < `ATOP_DATA_W / 8; b++) begin
          if (we_i && be_i[b]) mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: tb/tb_atop_resolver.sv
/*
 * Testbench for the atomic resolver. Requests and expected responses are
 * read from tb/atop_tests.txt relative to the project root, at most 64 tests.
 * Responses are checked in request order.
 */
`timescale 1ns/1ns
`include "atop_cfg.svh"

module tb_atop_resolver;

  localparam int    FIELDS     = 7;
  localparam int    MAX_TESTS  = 64;
  localparam int    CYCLES_PER = 40;
  localparam string TESTS_FILE = "tb/atop_tests.txt";

  typedef struct packed {
    atop_pkg::id_t   id;
    logic            exokay;
    atop_pkg::data_t rdata;
  } rsp_t;

  logic            clk;
  logic            rst_n;
  logic            sbr_req;
  logic            sbr_gnt;
  atop_pkg::addr_t sbr_addr;
  logic            sbr_we;
  atop_pkg::be_t   sbr_be;
  atop_pkg::data_t sbr_wdata;
  atop_pkg::id_t   sbr_aid;
  atop_pkg::atop_e sbr_atop;
  logic            sbr_rvalid;
  atop_pkg::data_t sbr_rdata;
  atop_pkg::id_t   sbr_rid;
  logic            sbr_err;
  logic            sbr_exokay;
  logic            mgr_req;
  logic            mgr_gnt;
  atop_pkg::addr_t mgr_addr;
  logic            mgr_we;
  atop_pkg::be_t   mgr_be;
  atop_pkg::data_t mgr_wdata;
  logic            mgr_rvalid;
  atop_pkg::data_t mgr_rdata;
  logic            mgr_err;

  logic [31:0] tests_mem [FIELDS*MAX_TESTS];
  rsp_t        exp_q [$];
  int          n_tests;
  int          rsp_count;
  int          value_errors;
  int          other_errors;
  logic        loaded;

  atop_resolver u_atop_resolver (
    .clk_i(clk), .rst_ni(rst_n),
    .sbr_req_i(sbr_req), .sbr_gnt_o(sbr_gnt), .sbr_addr_i(sbr_addr),
    .sbr_we_i(sbr_we), .sbr_be_i(sbr_be), .sbr_wdata_i(sbr_wdata),
    .sbr_aid_i(sbr_aid), .sbr_atop_i(sbr_atop),
    .sbr_rvalid_o(sbr_rvalid), .sbr_rdata_o(sbr_rdata), .sbr_rid_o(sbr_rid),
    .sbr_err_o(sbr_err), .sbr_exokay_o(sbr_exokay),
    .mgr_req_o(mgr_req), .mgr_gnt_i(mgr_gnt), .mgr_addr_o(mgr_addr),
    .mgr_we_o(mgr_we), .mgr_be_o(mgr_be), .mgr_wdata_o(mgr_wdata),
    .mgr_rvalid_i(mgr_rvalid), .mgr_rdata_i(mgr_rdata), .mgr_err_i(mgr_err)
  );

  tb_mem_model u_mem (
    .clk_i(clk), .rst_ni(rst_n),
    .req_i(mgr_req), .gnt_o(mgr_gnt), .addr_i(mgr_addr), .we_i(mgr_we),
    .be_i(mgr_be), .wdata_i(mgr_wdata),
    .rvalid_o(mgr_rvalid), .rdata_o(mgr_rdata), .err_o(mgr_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      value_errors++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, expected);
    end
  endtask

  task automatic load_tests();
    for (int k = 0; k < FIELDS * MAX_TESTS; k++) begin
      tests_mem[k] = '1;
    end
    $readmemh(TESTS_FILE, tests_mem);
    n_tests = 0;
    while (n_tests < MAX_TESTS && tests_mem[FIELDS*n_tests] != '1) n_tests++;
    assert (n_tests > 0) else begin
      other_errors++;
      $display("No tests could be read from %s", TESTS_FILE);
    end
  endtask

  task automatic drive_request(input int i);
    int   base;
    rsp_t expected;
    base      = FIELDS * i;
    sbr_req   <= 1'b1;
    sbr_aid   <= tests_mem[base][`ATOP_ID_W-1:0];
    sbr_atop  <= atop_pkg::atop_e'(tests_mem[base+1][5:0]);
    sbr_we    <= tests_mem[base+2][0];
    sbr_addr  <= tests_mem[base+3];
    sbr_wdata <= tests_mem[base+4];
    sbr_be    <= '1;
    expected.id     = tests_mem[base][`ATOP_ID_W-1:0];
    expected.rdata  = tests_mem[base+5];
    expected.exokay = tests_mem[base+6][0];
    exp_q.push_back(expected);
  endtask

  // Grant is sampled half a cycle after the inputs change
  task automatic wait_grant();
    do @(negedge clk); while (!sbr_gnt);
  endtask

  task automatic report_counts();
    $display("Error counts: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin : stimulus
    rst_n = 1'b0;
    sbr_req = 1'b0;
    sbr_addr = '0;
    sbr_we = 1'b0;
    sbr_be = '0;
    sbr_wdata = '0;
    sbr_aid = '0;
    sbr_atop = atop_pkg::ATOP_NONE;
    rsp_count = 0;
    value_errors = 0;
    other_errors = 0;
    loaded = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_tests; i++) begin
      @(posedge clk);
      drive_request(i);
      wait_grant();
    end
    @(posedge clk);
    sbr_req <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    // A few more cycles so a stray write-back response would show up
    repeat (5) @(negedge clk);
    check_value("response count", rsp_count, n_tests);
    assert (u_atop_resolver.u_ctrl.u_chk.fail_count == 0) else begin
      other_errors++;
      $display("Protocol assertions failed %0d times",
               u_atop_resolver.u_ctrl.u_chk.fail_count);
    end
    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Responses are compared in order at the falling edge
  always @(negedge clk) begin
    rsp_t expected;
    if (rst_n && sbr_rvalid) begin
      rsp_count++;
      assert (exp_q.size() != 0) else begin
        other_errors++;
        $display("Response at %0t ns arrived with no request waiting for one", $time);
      end
      if (exp_q.size() != 0) begin
        expected = exp_q.pop_front();
        check_value("sbr_rid_o", 32'(sbr_rid), 32'(expected.id));
        check_value("sbr_rdata_o", sbr_rdata, expected.rdata);
        check_value("sbr_exokay_o", 32'(sbr_exokay), 32'(expected.exokay));
        check_value("sbr_err_o", 32'(sbr_err), 32'h0);
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (n_tests * CYCLES_PER) @(posedge clk);
    other_errors++;
    $display("Timeout: responses still missing after %0d cycles", n_tests * CYCLES_PER);
    report_counts();
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: build.f
+incdir+include
hdl/atop_pkg.sv
hdl/atop_req_if.sv
hdl/atop_amo_ctrl.sv
hdl/atop_amo_alu.sv
hdl/atop_lrsc_monitor.sv
hdl/atop_rsp_path.sv
hdl/atop_resolver.sv
tb/atop_resolver_chk.sv
tb/tb_mem_model.sv
tb/tb_atop_resolver.sv

// File: Makefile
# Verilator flow for the atomic resolver testbench
VERILATOR ?= verilator
TOP       ?= tb_atop_resolver
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --timing --assert --timescale 1ns/1ns
SIM_FLAGS ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ] || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/atop_tests.txt
// Columns, all hex: id atop we addr wdata exp_rdata exp_exokay
// atop 00 is a plain access, we only matters for plain accesses and SC
1 00 1 00000000 11223344 00000000 0
2 00 0 00000000 00000000 11223344 0
3 00 1 00000004 0000000a 00000000 0
3 20 0 00000004 00000005 0000000a 0
4 00 0 00000004 00000000 0000000f 0
5 21 0 00000004 cafef00d 0000000f 0
5 00 0 00000004 00000000 cafef00d 0
1 00 1 00000008 f0f0f0f0 00000000 0
2 24 0 00000008 ff00ff00 f0f0f0f0 0
2 2c 0 00000008 0000ffff 0ff00ff0 0
2 28 0 00000008 12340000 00000ff0 0
2 00 0 00000008 00000000 12340ff0 0
6 00 1 0000000c fffffff0 00000000 0
6 30 0 0000000c 00000005 fffffff0 0
6 34 0 0000000c fffffffe fffffff0 0
6 38 0 0000000c 00000003 fffffffe 0
6 3c 0 0000000c 80000000 00000003 0
6 34 0 0000000c ffffffff 80000000 0
6 3c 0 0000000c 7fffffff ffffffff 0
6 38 0 0000000c 00000010 ffffffff 0
6 00 0 0000000c 00000000 00000010 0
7 00 1 00000010 00000064 00000000 0
7 22 0 00000010 00000000 00000064 1
7 23 1 00000010 000000c8 00000000 1
8 00 0 00000010 00000000 000000c8 0
7 22 0 00000010 00000000 000000c8 1
9 00 1 00000010 00000055 00000000 0
7 23 1 00000010 00000077 00000001 0
8 00 0 00000010 00000000 00000055 0
7 23 1 00000014 00000099 00000001 0
8 00 0 00000014 00000000 00000000 0
